// File: hw/branch_unit.sv
`default_nettype none

module branch_unit (
	input  wire [id_ctrl_pkg::BR_W-1:0]     br_kind_i,
	input  wire [mips_isa_pkg::XLEN-1:0]    pc_i,
	input  wire mips_isa_pkg::instr_u       inst_i,
	input  wire [mips_isa_pkg::XLEN-1:0]    rs_data_i,
	input  wire [mips_isa_pkg::XLEN-1:0]    rt_data_i,
	output logic                            taken_o,
	output logic [mips_isa_pkg::XLEN-1:0]   target_o
);

	logic [mips_isa_pkg::XLEN-1:0]        pc_plus4;
	logic [mips_isa_pkg::XLEN-1:0]        br_offset;
	logic signed [mips_isa_pkg::XLEN-1:0] rs_s;

	assign pc_plus4  = pc_i + 32'd4;
	assign br_offset = {{14{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16, 2'b00};
	assign rs_s      = rs_data_i;

	always_comb begin
		taken_o  = 1'b0;
		target_o = pc_plus4 + br_offset; // delay slot relative
		case (br_kind_i)
			id_ctrl_pkg::BR_JABS: begin
				taken_o  = 1'b1;
				target_o = {pc_plus4[31:28], inst_i.j_fmt.index26, 2'b00};
			end
			id_ctrl_pkg::BR_JREG: begin
				taken_o  = 1'b1;
				target_o = rs_data_i;
			end
			id_ctrl_pkg::BR_EQ:  taken_o = (rs_data_i == rt_data_i);
			id_ctrl_pkg::BR_NE:  taken_o = (rs_data_i != rt_data_i);
			// signed against zero
			id_ctrl_pkg::BR_LEZ: taken_o = (rs_s <= 0);
			id_ctrl_pkg::BR_GTZ: taken_o = (rs_s > 0);
			id_ctrl_pkg::BR_LTZ: taken_o = (rs_s < 0);
			id_ctrl_pkg::BR_GEZ: taken_o = (rs_s >= 0);
			default:             taken_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

	localparam int ALUOP_W  = 4;
	localparam int ALUSEL_W = 3;
	localparam int SRC_W    = 2;
	localparam int BR_W     = 4;

	localparam logic [ALUOP_W-1:0] ALUOP_NOP  = 4'd0;
	localparam logic [ALUOP_W-1:0] ALUOP_AND  = 4'd1;
	localparam logic [ALUOP_W-1:0] ALUOP_OR   = 4'd2;
	localparam logic [ALUOP_W-1:0] ALUOP_XOR  = 4'd3;
	localparam logic [ALUOP_W-1:0] ALUOP_NOR  = 4'd4;
	localparam logic [ALUOP_W-1:0] ALUOP_SLT  = 4'd5;
	localparam logic [ALUOP_W-1:0] ALUOP_SLTU = 4'd6;
	localparam logic [ALUOP_W-1:0] ALUOP_SLL  = 4'd7;
	localparam logic [ALUOP_W-1:0] ALUOP_SRL  = 4'd8;
	localparam logic [ALUOP_W-1:0] ALUOP_SRA  = 4'd9;
	localparam logic [ALUOP_W-1:0] ALUOP_ADD  = 4'd10;
	localparam logic [ALUOP_W-1:0] ALUOP_ADDU = 4'd11;
	localparam logic [ALUOP_W-1:0] ALUOP_SUB  = 4'd12;
	localparam logic [ALUOP_W-1:0] ALUOP_SUBU = 4'd13;
	localparam logic [ALUOP_W-1:0] ALUOP_LINK = 4'd14;

	// result class seen by execute
	localparam logic [ALUSEL_W-1:0] SEL_NOP     = 3'd0;
	localparam logic [ALUSEL_W-1:0] SEL_LOGIC   = 3'd1;
	localparam logic [ALUSEL_W-1:0] SEL_SHIFT   = 3'd2;
	localparam logic [ALUSEL_W-1:0] SEL_COMPARE = 3'd3;
	localparam logic [ALUSEL_W-1:0] SEL_ADD     = 3'd4;
	localparam logic [ALUSEL_W-1:0] SEL_LINK    = 3'd5;

	localparam logic [SRC_W-1:0] SRC_REG  = 2'd0;
	localparam logic [SRC_W-1:0] SRC_IMM  = 2'd1;
	localparam logic [SRC_W-1:0] SRC_LINK = 2'd2; // pc + 8
	localparam logic [SRC_W-1:0] SRC_ZERO = 2'd3;

	localparam logic [BR_W-1:0] BR_NONE = 4'd0;
	localparam logic [BR_W-1:0] BR_JABS = 4'd1;
	localparam logic [BR_W-1:0] BR_JREG = 4'd2;
	localparam logic [BR_W-1:0] BR_EQ   = 4'd3;
	localparam logic [BR_W-1:0] BR_NE   = 4'd4;
	localparam logic [BR_W-1:0] BR_LEZ  = 4'd5;
	localparam logic [BR_W-1:0] BR_GTZ  = 4'd6;
	localparam logic [BR_W-1:0] BR_LTZ  = 4'd7;
	localparam logic [BR_W-1:0] BR_GEZ  = 4'd8;

endpackage

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none

module id_stage (
	input  wire                                 clk,
	input  wire                                 rst_n_i,
	input  wire                                 inst_valid_i,
	output logic                                inst_ready_o,
	input  wire  [mips_isa_pkg::XLEN-1:0]       inst_pc_i,
	input  wire  mips_isa_pkg::instr_u          inst_i,
	input  wire                                 wb_we_i,
	input  wire  [mips_isa_pkg::REG_AW-1:0]     wb_addr_i,
	input  wire  [mips_isa_pkg::XLEN-1:0]       wb_data_i,
	output logic                                ex_valid_o,
	input  wire                                 ex_ready_i,
	output logic [id_ctrl_pkg::ALUOP_W-1:0]     ex_aluop_o,
	output logic [id_ctrl_pkg::ALUSEL_W-1:0]    ex_alusel_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_src1_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_src2_o,
	output logic [mips_isa_pkg::REG_AW-1:0]     ex_dest_o,
	output logic                                ex_wreg_o,
	output logic                                ex_invalid_o,
	output logic                                ex_branch_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_target_o
);

	logic [mips_isa_pkg::REG_AW-1:0]   rs_addr;
	logic [mips_isa_pkg::REG_AW-1:0]   rt_addr;
	logic [mips_isa_pkg::XLEN-1:0]     rs_data;
	logic [mips_isa_pkg::XLEN-1:0]     rt_data;
	logic [id_ctrl_pkg::ALUOP_W-1:0]   aluop;
	logic [id_ctrl_pkg::ALUSEL_W-1:0]  alusel;
	logic [id_ctrl_pkg::SRC_W-1:0]     src1_sel;
	logic [id_ctrl_pkg::SRC_W-1:0]     src2_sel;
	logic [mips_isa_pkg::XLEN-1:0]     imm;
	logic [mips_isa_pkg::REG_AW-1:0]   dest;
	logic                              wreg;
	logic                              invalid;
	logic [id_ctrl_pkg::BR_W-1:0]      br_kind;
	logic                              taken;
	logic [mips_isa_pkg::XLEN-1:0]     target;

	regfile u_regfile (
		.clk(clk), .rst_n_i(rst_n_i),
		.we_i(wb_we_i), .waddr_i(wb_addr_i), .wdata_i(wb_data_i),
		.raddr1_i(rs_addr), .raddr2_i(rt_addr),
		.rdata1_o(rs_data), .rdata2_o(rt_data)
	);

	inst_decoder u_decoder (
		.inst_i(inst_i),
		.rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
		.aluop_o(aluop), .alusel_o(alusel),
		.src1_sel_o(src1_sel), .src2_sel_o(src2_sel),
		.imm_o(imm),
		.dest_o(dest), .wreg_o(wreg), .invalid_o(invalid),
		.br_kind_o(br_kind)
	);

	branch_unit u_branch (
		.br_kind_i(br_kind), .pc_i(inst_pc_i), .inst_i(inst_i),
		.rs_data_i(rs_data), .rt_data_i(rt_data),
		.taken_o(taken), .target_o(target)
	);

	operand_issue u_issue (
		.clk(clk), .rst_n_i(rst_n_i),
		.in_valid_i(inst_valid_i), .in_ready_o(inst_ready_o),
		.pc_i(inst_pc_i), .rs_data_i(rs_data), .rt_data_i(rt_data), .imm_i(imm),
		.src1_sel_i(src1_sel), .src2_sel_i(src2_sel),
		.aluop_i(aluop), .alusel_i(alusel),
		.dest_i(dest), .wreg_i(wreg), .invalid_i(invalid),
		.taken_i(taken), .target_i(target),
		.out_valid_o(ex_valid_o), .out_ready_i(ex_ready_i),
		.ex_aluop_o(ex_aluop_o), .ex_alusel_o(ex_alusel_o),
		.ex_src1_o(ex_src1_o), .ex_src2_o(ex_src2_o),
		.ex_dest_o(ex_dest_o), .ex_wreg_o(ex_wreg_o), .ex_invalid_o(ex_invalid_o),
		.ex_branch_o(ex_branch_o), .ex_target_o(ex_target_o)
	);

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder (
	input  wire mips_isa_pkg::instr_u         inst_i,
	output logic [mips_isa_pkg::REG_AW-1:0]   rs_addr_o,
	output logic [mips_isa_pkg::REG_AW-1:0]   rt_addr_o,
	output logic [id_ctrl_pkg::ALUOP_W-1:0]   aluop_o,
	output logic [id_ctrl_pkg::ALUSEL_W-1:0]  alusel_o,
	output logic [id_ctrl_pkg::SRC_W-1:0]     src1_sel_o,
	output logic [id_ctrl_pkg::SRC_W-1:0]     src2_sel_o,
	output logic [mips_isa_pkg::XLEN-1:0]     imm_o,
	output logic [mips_isa_pkg::REG_AW-1:0]   dest_o,
	output logic                              wreg_o,
	output logic                              invalid_o,
	output logic [id_ctrl_pkg::BR_W-1:0]      br_kind_o
);

	logic [5:0]  op;
	logic [5:0]  funct;
	logic [15:0] imm16;
	logic        sa_shift;
	logic        imm_alu;
	logic        zext_imm;
	logic        link;

	assign op        = inst_i.r_fmt.op;
	assign funct     = inst_i.r_fmt.funct;
	assign imm16     = inst_i.i_fmt.imm16;
	assign rs_addr_o = inst_i.i_fmt.rs;
	assign rt_addr_o = inst_i.i_fmt.rt;

	assign sa_shift = (op == mips_isa_pkg::OP_SPECIAL) &&
		(funct inside {mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRA});
	assign imm_alu  = op inside {mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU,
		mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ANDI,
		mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI};
	assign zext_imm = op inside {mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
		mips_isa_pkg::OP_XORI};

	// sa goes out through the immediate path
	assign imm_o = sa_shift ? {{(mips_isa_pkg::XLEN-mips_isa_pkg::REG_AW){1'b0}},
			inst_i.r_fmt.sa} :
		(op == mips_isa_pkg::OP_LUI) ? {imm16, 16'h0000} :
		zext_imm ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	always_comb begin
		aluop_o    = id_ctrl_pkg::ALUOP_NOP;
		src1_sel_o = id_ctrl_pkg::SRC_REG;
		src2_sel_o = id_ctrl_pkg::SRC_REG;
		dest_o     = inst_i.i_fmt.rt;
		wreg_o     = 1'b0;
		invalid_o  = 1'b0;
		br_kind_o  = id_ctrl_pkg::BR_NONE;
		link       = 1'b0;
		case (op)
			mips_isa_pkg::OP_SPECIAL: begin
				dest_o = inst_i.r_fmt.rd;
				wreg_o = 1'b1;
				case (funct)
					mips_isa_pkg::FN_AND:  aluop_o = id_ctrl_pkg::ALUOP_AND;
					mips_isa_pkg::FN_OR:   aluop_o = id_ctrl_pkg::ALUOP_OR;
					mips_isa_pkg::FN_XOR:  aluop_o = id_ctrl_pkg::ALUOP_XOR;
					mips_isa_pkg::FN_NOR:  aluop_o = id_ctrl_pkg::ALUOP_NOR;
					mips_isa_pkg::FN_SLT:  aluop_o = id_ctrl_pkg::ALUOP_SLT;
					mips_isa_pkg::FN_SLTU: aluop_o = id_ctrl_pkg::ALUOP_SLTU;
					mips_isa_pkg::FN_SLL:  aluop_o = id_ctrl_pkg::ALUOP_SLL;
					mips_isa_pkg::FN_SRL:  aluop_o = id_ctrl_pkg::ALUOP_SRL;
					mips_isa_pkg::FN_SRA:  aluop_o = id_ctrl_pkg::ALUOP_SRA;
					mips_isa_pkg::FN_SLLV: aluop_o = id_ctrl_pkg::ALUOP_SLL;
					mips_isa_pkg::FN_SRLV: aluop_o = id_ctrl_pkg::ALUOP_SRL;
					mips_isa_pkg::FN_SRAV: aluop_o = id_ctrl_pkg::ALUOP_SRA;
					mips_isa_pkg::FN_ADD:  aluop_o = id_ctrl_pkg::ALUOP_ADD;
					mips_isa_pkg::FN_ADDU: aluop_o = id_ctrl_pkg::ALUOP_ADDU;
					mips_isa_pkg::FN_SUB:  aluop_o = id_ctrl_pkg::ALUOP_SUB;
					mips_isa_pkg::FN_SUBU: aluop_o = id_ctrl_pkg::ALUOP_SUBU;
					mips_isa_pkg::FN_JR: begin
						wreg_o    = 1'b0;
						br_kind_o = id_ctrl_pkg::BR_JREG;
					end
					mips_isa_pkg::FN_JALR: begin
						link      = 1'b1; // links into rd
						br_kind_o = id_ctrl_pkg::BR_JREG;
					end
					default: invalid_o = 1'b1;
				endcase
			end
			mips_isa_pkg::OP_REGIMM: begin
				case (inst_i.i_fmt.rt)
					mips_isa_pkg::RI_BLTZ: br_kind_o = id_ctrl_pkg::BR_LTZ;
					mips_isa_pkg::RI_BGEZ: br_kind_o = id_ctrl_pkg::BR_GEZ;
					mips_isa_pkg::RI_BLTZAL: begin
						link      = 1'b1;
						br_kind_o = id_ctrl_pkg::BR_LTZ;
					end
					mips_isa_pkg::RI_BGEZAL: begin
						link      = 1'b1;
						br_kind_o = id_ctrl_pkg::BR_GEZ;
					end
					default: invalid_o = 1'b1;
				endcase
			end
			mips_isa_pkg::OP_J: br_kind_o = id_ctrl_pkg::BR_JABS;
			mips_isa_pkg::OP_JAL: begin
				link      = 1'b1;
				br_kind_o = id_ctrl_pkg::BR_JABS;
			end
			mips_isa_pkg::OP_BEQ:   br_kind_o = id_ctrl_pkg::BR_EQ;
			mips_isa_pkg::OP_BNE:   br_kind_o = id_ctrl_pkg::BR_NE;
			mips_isa_pkg::OP_BLEZ:  br_kind_o = id_ctrl_pkg::BR_LEZ;
			mips_isa_pkg::OP_BGTZ:  br_kind_o = id_ctrl_pkg::BR_GTZ;
			mips_isa_pkg::OP_ANDI:  aluop_o = id_ctrl_pkg::ALUOP_AND;
			mips_isa_pkg::OP_ORI:   aluop_o = id_ctrl_pkg::ALUOP_OR;
			mips_isa_pkg::OP_XORI:  aluop_o = id_ctrl_pkg::ALUOP_XOR;
			mips_isa_pkg::OP_LUI:   aluop_o = id_ctrl_pkg::ALUOP_XOR; // rs ^ (imm << 16)
			mips_isa_pkg::OP_SLTI:  aluop_o = id_ctrl_pkg::ALUOP_SLT;
			mips_isa_pkg::OP_SLTIU: aluop_o = id_ctrl_pkg::ALUOP_SLTU;
			mips_isa_pkg::OP_ADDI:  aluop_o = id_ctrl_pkg::ALUOP_ADD;
			mips_isa_pkg::OP_ADDIU: aluop_o = id_ctrl_pkg::ALUOP_ADDU;
			default: invalid_o = 1'b1;
		endcase
		if (imm_alu) begin
			src2_sel_o = id_ctrl_pkg::SRC_IMM;
			wreg_o     = 1'b1;
		end
		if (sa_shift) begin
			src1_sel_o = id_ctrl_pkg::SRC_IMM;
		end
		// return address pc+8 through the alu
		if (link) begin
			aluop_o    = id_ctrl_pkg::ALUOP_LINK;
			src1_sel_o = id_ctrl_pkg::SRC_LINK;
			src2_sel_o = id_ctrl_pkg::SRC_ZERO;
			wreg_o     = 1'b1;
			if (op != mips_isa_pkg::OP_SPECIAL) begin
				dest_o = mips_isa_pkg::LINK_REG;
			end
		end
		if (invalid_o) begin
			wreg_o = 1'b0;
		end
	end

	// class follows from the op
	always_comb begin
		case (aluop_o)
			id_ctrl_pkg::ALUOP_AND, id_ctrl_pkg::ALUOP_OR, id_ctrl_pkg::ALUOP_XOR,
			id_ctrl_pkg::ALUOP_NOR:  alusel_o = id_ctrl_pkg::SEL_LOGIC;
			id_ctrl_pkg::ALUOP_SLT, id_ctrl_pkg::ALUOP_SLTU:
				alusel_o = id_ctrl_pkg::SEL_COMPARE;
			id_ctrl_pkg::ALUOP_SLL, id_ctrl_pkg::ALUOP_SRL, id_ctrl_pkg::ALUOP_SRA:
				alusel_o = id_ctrl_pkg::SEL_SHIFT;
			id_ctrl_pkg::ALUOP_ADD, id_ctrl_pkg::ALUOP_ADDU, id_ctrl_pkg::ALUOP_SUB,
			id_ctrl_pkg::ALUOP_SUBU: alusel_o = id_ctrl_pkg::SEL_ADD;
			id_ctrl_pkg::ALUOP_LINK: alusel_o = id_ctrl_pkg::SEL_LINK;
			default:                 alusel_o = id_ctrl_pkg::SEL_NOP;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	localparam logic [REG_AW-1:0] LINK_REG = 5'd31; // jal / bltzal / bgezal

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// SPECIAL funct field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// REGIMM codes sit in the rt field
	localparam logic [REG_AW-1:0] RI_BLTZ   = 5'h00;
	localparam logic [REG_AW-1:0] RI_BGEZ   = 5'h01;
	localparam logic [REG_AW-1:0] RI_BLTZAL = 5'h10;
	localparam logic [REG_AW-1:0] RI_BGEZAL = 5'h11;

	typedef union packed {
		struct packed {
			logic [5:0]        op;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
			logic [REG_AW-1:0] rd;
			logic [REG_AW-1:0] sa;
			logic [5:0]        funct;
		} r_fmt;
		struct packed {
			logic [5:0]        op;
			logic [REG_AW-1:0] rs;
			logic [REG_AW-1:0] rt;
			logic [15:0]       imm16;
		} i_fmt;
		struct packed {
			logic [5:0]  op;
			logic [25:0] index26;
		} j_fmt;
	} instr_u;

endpackage

`default_nettype wire

// File: hw/operand_issue.sv
`default_nettype none

module operand_issue (
	input  wire                                 clk,
	input  wire                                 rst_n_i,
	input  wire                                 in_valid_i,
	output logic                                in_ready_o,
	input  wire  [mips_isa_pkg::XLEN-1:0]       pc_i,
	input  wire  [mips_isa_pkg::XLEN-1:0]       rs_data_i,
	input  wire  [mips_isa_pkg::XLEN-1:0]       rt_data_i,
	input  wire  [mips_isa_pkg::XLEN-1:0]       imm_i,
	input  wire  [id_ctrl_pkg::SRC_W-1:0]       src1_sel_i,
	input  wire  [id_ctrl_pkg::SRC_W-1:0]       src2_sel_i,
	input  wire  [id_ctrl_pkg::ALUOP_W-1:0]     aluop_i,
	input  wire  [id_ctrl_pkg::ALUSEL_W-1:0]    alusel_i,
	input  wire  [mips_isa_pkg::REG_AW-1:0]     dest_i,
	input  wire                                 wreg_i,
	input  wire                                 invalid_i,
	input  wire                                 taken_i,
	input  wire  [mips_isa_pkg::XLEN-1:0]       target_i,
	output logic                                out_valid_o,
	input  wire                                 out_ready_i,
	output logic [id_ctrl_pkg::ALUOP_W-1:0]     ex_aluop_o,
	output logic [id_ctrl_pkg::ALUSEL_W-1:0]    ex_alusel_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_src1_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_src2_o,
	output logic [mips_isa_pkg::REG_AW-1:0]     ex_dest_o,
	output logic                                ex_wreg_o,
	output logic                                ex_invalid_o,
	output logic                                ex_branch_o,
	output logic [mips_isa_pkg::XLEN-1:0]       ex_target_o
);

	logic [mips_isa_pkg::XLEN-1:0] pc_plus8;

	function automatic logic [mips_isa_pkg::XLEN-1:0] pick_src(
		input logic [id_ctrl_pkg::SRC_W-1:0]  sel,
		input logic [mips_isa_pkg::XLEN-1:0]  reg_val,
		input logic [mips_isa_pkg::XLEN-1:0]  imm,
		input logic [mips_isa_pkg::XLEN-1:0]  link
	);
		case (sel)
			id_ctrl_pkg::SRC_REG:  return reg_val;
			id_ctrl_pkg::SRC_IMM:  return imm;
			id_ctrl_pkg::SRC_LINK: return link;
			default:               return '0;
		endcase
	endfunction

	assign pc_plus8   = pc_i + 32'd8;
	assign in_ready_o = !out_valid_o || out_ready_i; // slot empty or draining

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			ex_aluop_o   <= aluop_i;
			ex_alusel_o  <= alusel_i;
			ex_src1_o    <= pick_src(src1_sel_i, rs_data_i, imm_i, pc_plus8);
			ex_src2_o    <= pick_src(src2_sel_i, rt_data_i, imm_i, pc_plus8);
			ex_dest_o    <= dest_i;
			ex_wreg_o    <= wreg_i;
			ex_invalid_o <= invalid_i;
			ex_branch_o  <= taken_i;
			ex_target_o  <= target_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

module regfile (
	input  wire         clk,
	input  wire         rst_n_i,
	input  wire         we_i,
	input  wire  [4:0]  waddr_i,
	input  wire  [31:0] wdata_i,
	input  wire  [4:0]  raddr1_i,
	input  wire  [4:0]  raddr2_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	// r0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != 5'd0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// no write-through, a write shows up the cycle after
	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: project.f
+incdir+verif
hw/mips_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/branch_unit.sv
hw/operand_issue.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: verif/id_stage_table.svh
`ifndef ID_STAGE_TABLE_SVH
`define ID_STAGE_TABLE_SVH

// write-back values for r0..r6 with r0 expected to keep reading zero
localparam logic [31:0] PRELOAD [0:6] = '{
	32'h1234_5678, 32'h0000_0005, 32'hffff_fff0, 32'h0000_0005,
	32'h8000_0000, 32'h0040_0100, 32'hffff_ffff
};

// columns are pc, instruction, aluop, alusel, src1, src2, dest, wreg, invalid, branch, target
// r7 is never written, so it reads zero
task automatic fill_table();
	add_row(32'h0000_0100, 32'h0007_4020, id_ctrl_pkg::ALUOP_ADD, id_ctrl_pkg::SEL_ADD,
		32'h0000_0000, 32'h0000_0000, 5'd8, 1, 0, 0, 32'h0); // add $8,$0,$7
	add_row(32'h0000_0104, 32'h0022_4824, id_ctrl_pkg::ALUOP_AND, id_ctrl_pkg::SEL_LOGIC,
		32'h0000_0005, 32'hffff_fff0, 5'd9, 1, 0, 0, 32'h0); // and $9,$1,$2
	add_row(32'h0000_0108, 32'h0041_682a, id_ctrl_pkg::ALUOP_SLT, id_ctrl_pkg::SEL_COMPARE,
		32'hffff_fff0, 32'h0000_0005, 5'd13, 1, 0, 0, 32'h0); // slt $13,$2,$1
	add_row(32'h0000_010c, 32'h00c3_8823, id_ctrl_pkg::ALUOP_SUBU, id_ctrl_pkg::SEL_ADD,
		32'hffff_ffff, 32'h0000_0005, 5'd17, 1, 0, 0, 32'h0); // subu $17,$6,$3
	add_row(32'h0000_0110, 32'h0002_9100, id_ctrl_pkg::ALUOP_SLL, id_ctrl_pkg::SEL_SHIFT,
		32'h0000_0004, 32'hffff_fff0, 5'd18, 1, 0, 0, 32'h0); // sll $18,$2,4
	add_row(32'h0000_0114, 32'h0022_b807, id_ctrl_pkg::ALUOP_SRA, id_ctrl_pkg::SEL_SHIFT,
		32'h0000_0005, 32'hffff_fff0, 5'd23, 1, 0, 0, 32'h0); // srav $23,$2,$1
	add_row(32'h0000_0118, 32'h3058_8001, id_ctrl_pkg::ALUOP_AND, id_ctrl_pkg::SEL_LOGIC,
		32'hffff_fff0, 32'h0000_8001, 5'd24, 1, 0, 0, 32'h0); // andi $24,$2,0x8001
	add_row(32'h0000_011c, 32'h2039_fffd, id_ctrl_pkg::ALUOP_ADD, id_ctrl_pkg::SEL_ADD,
		32'h0000_0005, 32'hffff_fffd, 5'd25, 1, 0, 0, 32'h0); // addi $25,$1,-3
	add_row(32'h0000_0120, 32'h2cda_8000, id_ctrl_pkg::ALUOP_SLTU, id_ctrl_pkg::SEL_COMPARE,
		32'hffff_ffff, 32'hffff_8000, 5'd26, 1, 0, 0, 32'h0); // sltiu $26,$6,0x8000
	add_row(32'h0000_0124, 32'h3c1b_1234, id_ctrl_pkg::ALUOP_XOR, id_ctrl_pkg::SEL_LOGIC,
		32'h0000_0000, 32'h1234_0000, 5'd27, 1, 0, 0, 32'h0); // lui $27,0x1234
	add_row(32'h0000_0128, 32'h0024_5025, id_ctrl_pkg::ALUOP_OR, id_ctrl_pkg::SEL_LOGIC,
		32'h0000_0005, 32'h8000_0000, 5'd10, 1, 0, 0, 32'h0); // or $10,$1,$4
	add_row(32'h0000_012c, 32'h0046_5826, id_ctrl_pkg::ALUOP_XOR, id_ctrl_pkg::SEL_LOGIC,
		32'hffff_fff0, 32'hffff_ffff, 5'd11, 1, 0, 0, 32'h0); // xor $11,$2,$6
	add_row(32'h0000_0130, 32'h0065_6027, id_ctrl_pkg::ALUOP_NOR, id_ctrl_pkg::SEL_LOGIC,
		32'h0000_0005, 32'h0040_0100, 5'd12, 1, 0, 0, 32'h0); // nor $12,$3,$5
	add_row(32'h0000_0134, 32'h0041_702b, id_ctrl_pkg::ALUOP_SLTU, id_ctrl_pkg::SEL_COMPARE,
		32'hffff_fff0, 32'h0000_0005, 5'd14, 1, 0, 0, 32'h0); // sltu $14,$2,$1
	add_row(32'h0000_0138, 32'h0004_7fc2, id_ctrl_pkg::ALUOP_SRL, id_ctrl_pkg::SEL_SHIFT,
		32'h0000_001f, 32'h8000_0000, 5'd15, 1, 0, 0, 32'h0); // srl $15,$4,31
	add_row(32'h0000_013c, 32'h0006_8043, id_ctrl_pkg::ALUOP_SRA, id_ctrl_pkg::SEL_SHIFT,
		32'h0000_0001, 32'hffff_ffff, 5'd16, 1, 0, 0, 32'h0); // sra $16,$6,1
	add_row(32'h0000_0140, 32'h0024_9804, id_ctrl_pkg::ALUOP_SLL, id_ctrl_pkg::SEL_SHIFT,
		32'h0000_0005, 32'h8000_0000, 5'd19, 1, 0, 0, 32'h0); // sllv $19,$4,$1
	add_row(32'h0000_0144, 32'h00a2_a006, id_ctrl_pkg::ALUOP_SRL, id_ctrl_pkg::SEL_SHIFT,
		32'h0040_0100, 32'hffff_fff0, 5'd20, 1, 0, 0, 32'h0); // srlv $20,$2,$5
	add_row(32'h0000_0148, 32'h0086_a821, id_ctrl_pkg::ALUOP_ADDU, id_ctrl_pkg::SEL_ADD,
		32'h8000_0000, 32'hffff_ffff, 5'd21, 1, 0, 0, 32'h0); // addu $21,$4,$6
	add_row(32'h0000_014c, 32'h00a2_b022, id_ctrl_pkg::ALUOP_SUB, id_ctrl_pkg::SEL_ADD,
		32'h0040_0100, 32'hffff_fff0, 5'd22, 1, 0, 0, 32'h0); // sub $22,$5,$2
	add_row(32'h0000_0150, 32'h349c_f00f, id_ctrl_pkg::ALUOP_OR, id_ctrl_pkg::SEL_LOGIC,
		32'h8000_0000, 32'h0000_f00f, 5'd28, 1, 0, 0, 32'h0); // ori $28,$4,0xf00f
	add_row(32'h0000_0154, 32'h38dd_8000, id_ctrl_pkg::ALUOP_XOR, id_ctrl_pkg::SEL_LOGIC,
		32'hffff_ffff, 32'h0000_8000, 5'd29, 1, 0, 0, 32'h0); // xori $29,$6,0x8000
	add_row(32'h0000_0158, 32'h285e_ffff, id_ctrl_pkg::ALUOP_SLT, id_ctrl_pkg::SEL_COMPARE,
		32'hffff_fff0, 32'hffff_ffff, 5'd30, 1, 0, 0, 32'h0); // slti $30,$2,-1
	add_row(32'h0000_015c, 32'h247f_fff8, id_ctrl_pkg::ALUOP_ADDU, id_ctrl_pkg::SEL_ADD,
		32'h0000_0005, 32'hffff_fff8, 5'd31, 1, 0, 0, 32'h0); // addiu $31,$3,-8
	add_row(32'h9000_0010, 32'h0800_0040, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0000, 32'h0000_0000, 5'd0, 0, 0, 1, 32'h9000_0100); // j
	add_row(32'h0040_0020, 32'h0c00_0080, id_ctrl_pkg::ALUOP_LINK, id_ctrl_pkg::SEL_LINK,
		32'h0040_0028, 32'h0000_0000, 5'd31, 1, 0, 1, 32'h0000_0200); // jal
	add_row(32'h0000_2000, 32'h00a0_0008, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0040_0100, 32'h0000_0000, 5'd0, 0, 0, 1, 32'h0040_0100); // jr $5
	add_row(32'h0000_3000, 32'h00a0_f009, id_ctrl_pkg::ALUOP_LINK, id_ctrl_pkg::SEL_LINK,
		32'h0000_3008, 32'h0000_0000, 5'd30, 1, 0, 1, 32'h0040_0100); // jalr $30,$5
	add_row(32'h0000_1000, 32'h1023_0004, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0005, 32'h0000_0005, 5'd0, 0, 0, 1, 32'h0000_1014); // beq $1,$3,+4
	add_row(32'h0000_1010, 32'h1423_0004, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0005, 32'h0000_0005, 5'd0, 0, 0, 0, 32'h0); // bne $1,$3,+4
	add_row(32'h0000_1100, 32'h1840_fffe, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'hffff_fff0, 32'h0000_0000, 5'd0, 0, 0, 1, 32'h0000_10fc); // blez $2,-2
	add_row(32'h0000_1200, 32'h1c80_0002, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h8000_0000, 32'h0000_0000, 5'd0, 0, 0, 0, 32'h0); // bgtz $4 with r4 negative
	add_row(32'h0000_1400, 32'h04d0_0003, id_ctrl_pkg::ALUOP_LINK, id_ctrl_pkg::SEL_LINK,
		32'h0000_1408, 32'h0000_0000, 5'd31, 1, 0, 1, 32'h0000_1410); // bltzal $6,+3
	add_row(32'h0000_1500, 32'h0491_0001, id_ctrl_pkg::ALUOP_LINK, id_ctrl_pkg::SEL_LINK,
		32'h0000_1508, 32'h0000_0000, 5'd31, 1, 0, 0, 32'h0); // bgezal $4,+1
	// rt field holds the code 1, so src2 shows r1
	add_row(32'h0000_1600, 32'h04e1_0002, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0000, 32'h0000_0005, 5'd0, 0, 0, 1, 32'h0000_160c); // bgez $7,+2
	add_row(32'h0000_1700, 32'h0423_0000, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0005, 32'h0000_0005, 5'd0, 0, 1, 0, 32'h0); // regimm code 3
	add_row(32'h0000_1800, 32'h8c00_0000, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0000, 32'h0000_0000, 5'd0, 0, 1, 0, 32'h0); // opcode 0x23
	add_row(32'h0000_1804, 32'h0022_0018, id_ctrl_pkg::ALUOP_NOP, id_ctrl_pkg::SEL_NOP,
		32'h0000_0005, 32'hffff_fff0, 5'd0, 0, 1, 0, 32'h0); // mult is dropped
endtask

`endif

// File: verif/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

	localparam int TIMEOUT = 50; // cycles per wait

	typedef struct packed {
		logic [31:0]                      pc;
		logic [31:0]                      inst;
		logic [id_ctrl_pkg::ALUOP_W-1:0]  aluop;
		logic [id_ctrl_pkg::ALUSEL_W-1:0] alusel;
		logic [31:0]                      src1;
		logic [31:0]                      src2;
		logic [4:0]                       dest;
		logic                             wreg;
		logic                             invalid;
		logic                             branch;
		logic [31:0]                      target;
	} row_t;

	logic        clk;
	logic        rst_n_i;
	logic        inst_valid_i;
	logic        inst_ready_o;
	logic [31:0] inst_pc_i;
	logic [31:0] inst_i;
	logic        wb_we_i;
	logic [4:0]  wb_addr_i;
	logic [31:0] wb_data_i;
	logic        ex_valid_o;
	logic        ex_ready_i;
	logic [3:0]  ex_aluop_o;
	logic [2:0]  ex_alusel_o;
	logic [31:0] ex_src1_o;
	logic [31:0] ex_src2_o;
	logic [4:0]  ex_dest_o;
	logic        ex_wreg_o;
	logic        ex_invalid_o;
	logic        ex_branch_o;
	logic [31:0] ex_target_o;
	integer      seed;
	row_t        rows[$];

	id_stage uut (
		.clk(clk), .rst_n_i(rst_n_i),
		.inst_valid_i(inst_valid_i), .inst_ready_o(inst_ready_o),
		.inst_pc_i(inst_pc_i), .inst_i(inst_i),
		.wb_we_i(wb_we_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
		.ex_valid_o(ex_valid_o), .ex_ready_i(ex_ready_i),
		.ex_aluop_o(ex_aluop_o), .ex_alusel_o(ex_alusel_o),
		.ex_src1_o(ex_src1_o), .ex_src2_o(ex_src2_o),
		.ex_dest_o(ex_dest_o), .ex_wreg_o(ex_wreg_o), .ex_invalid_o(ex_invalid_o),
		.ex_branch_o(ex_branch_o), .ex_target_o(ex_target_o)
	);

	`include "id_stage_table.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic add_row(input logic [31:0] pc, input logic [31:0] inst,
		input logic [3:0] aluop, input logic [2:0] alusel,
		input logic [31:0] src1, input logic [31:0] src2, input logic [4:0] dest,
		input logic wreg, input logic invalid, input logic branch, input logic [31:0] target);
		row_t r;
		r = '{pc, inst, aluop, alusel, src1, src2, dest, wreg, invalid, branch, target};
		rows.push_back(r);
	endtask

	task automatic stop_with_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		stop_with_failure();
	endtask

	task automatic check_bundle(input row_t r);
		check_value("ex_aluop_o", ex_aluop_o, r.aluop);
		check_value("ex_alusel_o", ex_alusel_o, r.alusel);
		check_value("ex_src1_o", ex_src1_o, r.src1);
		check_value("ex_src2_o", ex_src2_o, r.src2);
		check_value("ex_wreg_o", ex_wreg_o, r.wreg);
		check_value("ex_invalid_o", ex_invalid_o, r.invalid);
		check_value("ex_branch_o", ex_branch_o, r.branch);
		if (r.wreg)
			check_value("ex_dest_o", ex_dest_o, r.dest);
		if (r.branch)
			check_value("ex_target_o", ex_target_o, r.target);
	endtask

	// holds each row on the input until the stage takes it
	task automatic issue_rows();
		int waited;
		foreach (rows[i]) begin
			@(negedge clk);
			inst_valid_i = 1'b1;
			inst_pc_i    = rows[i].pc;
			inst_i       = rows[i].inst;
			#1;
			waited = 0;
			while (!inst_ready_o) begin
				waited++;
				if (waited > TIMEOUT)
					report_timeout("inst_ready_o");
				@(negedge clk);
				#1;
			end
		end
		@(negedge clk);
		inst_valid_i = 1'b0;
	endtask

	// random back-pressure, bundle rechecked every stalled cycle
	task automatic collect_rows();
		int waited;
		foreach (rows[i]) begin
			waited = 0;
			do begin
				@(negedge clk);
				ex_ready_i = ($random(seed) & 3) != 0;
				#1;
				waited++;
				if (waited > TIMEOUT)
					report_timeout("ex_valid_o");
			end while (!ex_valid_o);
			check_bundle(rows[i]);
			waited = 0;
			while (!ex_ready_i) begin
				waited++;
				if (waited > TIMEOUT)
					report_timeout("ex_ready_i to release a stalled row");
				@(negedge clk);
				ex_ready_i = ($random(seed) & 3) != 0;
				#1;
				check_value("ex_valid_o", ex_valid_o, 1'b1);
				check_bundle(rows[i]);
			end
		end
	endtask

	initial begin
		seed         = 32'he996_5437;
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		inst_pc_i    = '0;
		inst_i       = '0;
		wb_we_i      = 1'b0;
		wb_addr_i    = '0;
		wb_data_i    = '0;
		ex_ready_i   = 1'b0;
		fill_table();
		repeat (4) @(negedge clk);
		rst_n_i = 1'b1;
		#1;
		check_value("ex_valid_o", ex_valid_o, 1'b0);
		check_value("inst_ready_o", inst_ready_o, 1'b1);
		for (int r = 0; r < $size(PRELOAD); r++) begin
			@(negedge clk);
			wb_we_i   = 1'b1;
			wb_addr_i = r[4:0];
			wb_data_i = PRELOAD[r];
		end
		@(negedge clk);
		wb_we_i = 1'b0;
		fork
			issue_rows();
			collect_rows();
		join
		@(negedge clk);
		#1;
		check_value("ex_valid_o", ex_valid_o, 1'b0); // nothing extra comes out
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
